// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic o_clk,
   output logic o_rst
);

   localparam time HALF_PERIOD = 10ns;  // 20 ns clock
   localparam int  RST_CYCLES  = 4;

   initial begin
      o_clk = 1'b0;
      forever #(HALF_PERIOD) o_clk = ~o_clk;
   end

   initial begin
      o_rst = 1'b1;
      repeat (RST_CYCLES) @(posedge o_clk);
      o_rst <= 1'b0;  // released on a rising edge
   end

endmodule

`default_nettype wire

// ==== dv/uart_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_checker (
   input logic i_clk,
   input logic i_rst,
   input logic i_psel,
   input logic i_penable,
   input logic i_pready,
   input logic i_pslverr,
   input logic i_tx,
   input logic i_tx_busy,
   input logic i_rx_valid,
   input logic i_irq
);

   // no wait states on this slave
   pready_high: assert property (@(posedge i_clk) disable iff (i_rst) i_pready)
      else $error("o_pready went low");

   pslverr_in_access: assert property (@(posedge i_clk) disable iff (i_rst)
      i_pslverr |-> (i_psel && i_penable))
      else $error("o_pslverr high outside an access phase");

   // idle line level between frames
   tx_idle_high: assert property (@(posedge i_clk) disable iff (i_rst)
      !i_tx_busy |-> i_tx)
      else $error("o_tx low while the transmitter is idle");

   irq_needs_rx_valid: assert property (@(posedge i_clk) disable iff (i_rst)
      $rose(i_irq) |-> $past(i_rx_valid))
      else $error("o_irq rose without a receive valid pulse");

endmodule

bind uart_top uart_checker u_checker (
   .i_clk      (i_clk),
   .i_rst      (i_rst),
   .i_psel     (i_psel),
   .i_penable  (i_penable),
   .i_pready   (o_pready),
   .i_pslverr  (o_pslverr),
   .i_tx       (o_tx),
   .i_tx_busy  (tx_busy),
   .i_rx_valid (rx_valid),
   .i_irq      (o_irq)
);

`default_nettype wire

// ==== dv/uart_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tb import uart_pkg::*; ();

   localparam logic [31:0] LFSR_SEED = 32'h2a93;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
   localparam int DIV_TX     = 3;
   localparam int DIV_FAST   = 1;
   localparam int DIV_SLOW   = 5;
   localparam int N_LOOP     = 3;  // loopback bytes per divisor
   localparam int FRAME_TX   = 10 * OVERSAMPLE * (DIV_TX + 1);
   localparam int FRAME_FAST = 10 * OVERSAMPLE * (DIV_FAST + 1);
   localparam int FRAME_SLOW = 10 * OVERSAMPLE * (DIV_SLOW + 1);
   // framing test, busy test with its idle window, loopback, three driven frames
   localparam int TIMEOUT_CYCLES =
      2 * (3 * FRAME_TX + N_LOOP * (FRAME_FAST + FRAME_SLOW) + 3 * FRAME_FAST) + 1000;

   logic        clk;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   apb_addr_t   paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        line_drv;   // testbench serial source
   logic        loopback;   // 1 routes o_tx back to i_rx
   logic        rx_line;
   logic        tx_line;
   logic        irq;
   logic [31:0] lfsr_state = LFSR_SEED;
   int          cycle_cnt  = 0;

   assign rx_line = loopback ? tx_line : line_drv;

   tb_clock_gen u_clock_gen (
      .o_clk (clk),
      .o_rst (rst)
   );

   uart_top u_uart_top (
      .i_clk     (clk),
      .i_rst     (rst),
      .i_psel    (psel),
      .i_penable (penable),
      .i_pwrite  (pwrite),
      .i_paddr   (paddr),
      .i_pwdata  (pwdata),
      .o_prdata  (prdata),
      .o_pready  (pready),
      .o_pslverr (pslverr),
      .i_rx      (rx_line),
      .o_tx      (tx_line),
      .o_irq     (irq)
   );

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation FAILED");
         $fatal(1, "cycle limit reached");
      end
   end

   task automatic fail_run(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Simulation FAILED");
      $fatal(1, "%s", msg);
   endtask

   task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
         $display("Simulation FAILED");
         $fatal(1, "%s check failed", what);
      end
   endtask

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ LFSR_TAPS;
      end
      return s >> 1;
   endfunction

   task automatic next_byte(output uart_data_t b);
      for (int i = 0; i < DATA_W; i++) begin
         lfsr_state = lfsr_step(lfsr_state);  // one step per bit
         b[i] = lfsr_state[0];
      end
   endtask

   task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;  // setup phase
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel    <= 1'b0;  // write lands on this edge
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);  // mid access phase
      data = prdata;
      err  = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic wait_tx_idle();
      logic [31:0] st;
      logic        err;
      st = 32'h1;
      while (st[0]) begin
         apb_read(REG_STATUS, st, err);
      end
   endtask

   // one frame on the driven line
   // a low stop bit lasts 3/4 of a bit so the receiver never takes it for a new start bit
   task automatic drive_frame(input uart_data_t data, input logic stop_level, input int bit_clks);
      logic [9:0] frame;
      frame = {stop_level, data, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         line_drv <= frame[i];
         if (i == 9 && !stop_level) begin
            repeat (bit_clks * 3 / 4 - 1) @(posedge clk);
         end else begin
            repeat (bit_clks - 1) @(posedge clk);
         end
      end
      @(posedge clk);
      line_drv <= 1'b1;
      repeat (bit_clks - 1) @(posedge clk);  // one idle bit
   endtask

   // samples o_tx mid-bit and checks that every edge sits on the bit grid
   task automatic capture_frame(input int bit_clks, output uart_data_t data, output logic stop);
      logic prev;
      int   idx;
      @(negedge clk);
      while (tx_line) @(negedge clk);
      prev = 1'b0;
      for (int n = 1; n < 10 * bit_clks; n++) begin  // clocks since the start edge
         @(negedge clk);
         if (tx_line !== prev) begin
            assert (n % bit_clks == 0) else
               fail_run($sformatf("o_tx edge %0d clocks after start is off the %0d clock grid",
                                  n, bit_clks));
         end
         prev = tx_line;
         if (n % bit_clks == bit_clks / 2) begin
            idx = n / bit_clks;
            if (idx == 0) begin
               expect_eq("start bit", tx_line, 1'b0);
            end else if (idx <= DATA_W) begin
               data[idx-1] = tx_line;
            end else begin
               stop = tx_line;
            end
         end
      end
   endtask

   task automatic check_line_idle(input int clks);
      repeat (clks) begin
         @(negedge clk);
         assert (tx_line === 1'b1) else fail_run("o_tx left idle after a dropped write");
      end
   endtask

   task automatic test_reset_state();
      logic [31:0] rd;
      logic        err;
      @(negedge clk);
      expect_eq("o_tx after reset", tx_line, 1'b1);
      expect_eq("o_irq after reset", irq, 1'b0);
      expect_eq("o_pready after reset", pready, 1'b1);
      apb_read(REG_STATUS, rd, err);
      expect_eq("STATUS after reset", rd, 32'h0);
      expect_eq("PSLVERR on STATUS", err, 1'b0);
      apb_read(REG_DIV, rd, err);
      expect_eq("DIV after reset", rd, 32'h0);
      apb_read(4'h2, rd, err);
      expect_eq("PSLVERR on offset 0x2", err, 1'b1);
   endtask

   task automatic test_tx_framing();
      uart_data_t  b;
      uart_data_t  got;
      logic        stop;
      logic [31:0] rd;
      logic [31:0] st_mid;
      logic        err;
      int          bit_clks;
      bit_clks = OVERSAMPLE * (DIV_TX + 1);
      apb_write(REG_DIV, DIV_TX);
      apb_read(REG_DIV, rd, err);
      expect_eq("DIV readback", rd, DIV_TX);
      next_byte(b);
      apb_write(REG_TXDATA, {24'h0, b});
      fork
         capture_frame(bit_clks, got, stop);
         begin
            repeat (3 * bit_clks) @(posedge clk);
            apb_read(REG_STATUS, st_mid, err);
         end
      join
      expect_eq("busy during frame", st_mid[0], 1'b1);
      expect_eq("transmitted byte", got, b);
      expect_eq("stop bit", stop, 1'b1);
      wait_tx_idle();
      apb_read(REG_STATUS, rd, err);
      expect_eq("STATUS after frame", rd, 32'h0);
   endtask

   task automatic test_busy_drop();
      uart_data_t  first;
      uart_data_t  second;
      uart_data_t  got;
      logic        stop;
      logic [31:0] rd;
      logic        err;
      int          bit_clks;
      bit_clks = OVERSAMPLE * (DIV_TX + 1);
      next_byte(first);
      next_byte(second);
      apb_write(REG_TXDATA, {24'h0, first});
      fork
         capture_frame(bit_clks, got, stop);
         begin
            repeat (5 * bit_clks) @(posedge clk);
            apb_write(REG_TXDATA, {24'h0, second});  // lands mid frame
         end
      join
      expect_eq("byte on line with write while busy", got, first);
      expect_eq("stop bit", stop, 1'b1);
      check_line_idle(FRAME_TX);  // a queued second frame would start right here
      apb_read(REG_STATUS, rd, err);
      expect_eq("STATUS after dropped write", rd, 32'h0);
   endtask

   task automatic loop_one_byte();
      uart_data_t  b;
      logic [31:0] rd;
      logic        err;
      next_byte(b);
      apb_write(REG_TXDATA, {24'h0, b});
      wait_tx_idle();
      @(negedge clk);
      expect_eq("o_irq after loopback frame", irq, 1'b1);
      apb_read(REG_STATUS, rd, err);
      expect_eq("STATUS after loopback frame", rd, 32'h2);
      apb_read(REG_RXDATA, rd, err);
      expect_eq("RXDATA in loopback", rd, {24'h0, b});
      apb_read(REG_STATUS, rd, err);
      expect_eq("STATUS after RXDATA read", rd, 32'h0);
      @(negedge clk);
      expect_eq("o_irq after RXDATA read", irq, 1'b0);
   endtask

   task automatic test_loopback();
      @(posedge clk);
      loopback <= 1'b1;
      apb_write(REG_DIV, DIV_FAST);
      repeat (N_LOOP) loop_one_byte();
      apb_write(REG_DIV, DIV_SLOW);
      repeat (N_LOOP) loop_one_byte();
   endtask

   task automatic test_rx_errors();
      uart_data_t  b1;
      uart_data_t  b2;
      logic [31:0] rd;
      logic        err;
      int          bit_clks;
      bit_clks = OVERSAMPLE * (DIV_FAST + 1);
      @(posedge clk);
      loopback <= 1'b0;
      apb_write(REG_DIV, DIV_FAST);
      next_byte(b1);
      drive_frame(b1, 1'b0, bit_clks);
      apb_read(REG_STATUS, rd, err);
      expect_eq("STATUS after bad stop bit", rd, 32'h4);  // frame_err only
      @(negedge clk);
      expect_eq("o_irq after bad stop bit", irq, 1'b0);
      apb_write(REG_STATUS, 32'h4);
      apb_read(REG_STATUS, rd, err);
      expect_eq("STATUS after frame_err clear", rd, 32'h0);
      next_byte(b1);
      next_byte(b2);
      drive_frame(b1, 1'b1, bit_clks);
      drive_frame(b2, 1'b1, bit_clks);
      apb_read(REG_STATUS, rd, err);
      expect_eq("STATUS after two unread frames", rd, 32'ha);
      apb_read(REG_RXDATA, rd, err);
      expect_eq("RXDATA after overrun", rd, {24'h0, b2});
      apb_read(REG_STATUS, rd, err);
      expect_eq("STATUS after overrun read", rd, 32'h0);
   endtask

   initial begin
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      line_drv = 1'b1;  // idle line
      loopback = 1'b0;
      wait (rst === 1'b0);
      @(posedge clk);
      test_reset_state();
      test_tx_framing();
      test_busy_drop();
      test_loopback();
      test_rx_errors();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/uart_pkg.sv
verilog/baud_tick_gen.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_apb_regs.sv
verilog/uart_top.sv
dv/tb_clock_gen.sv
dv/uart_checker.sv
dv/uart_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UART testbench with Verilator.
# The exit status is the simulation result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f flist.f \
   --top-module uart_tb \
   -o uart_sim

./obj_dir/uart_sim

// ==== verilog/baud_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen import uart_pkg::*; (
   input  logic      i_clk,
   input  logic      i_rst,
   input  baud_div_t i_div,
   output logic      o_rate
);

   baud_div_t cnt;    // counts down to zero
   baud_div_t div_q;  // divisor the count was loaded from

   // one tick every i_div + 1 clocks; a new divisor restarts the count
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt    <= i_div;
         div_q  <= i_div;
         o_rate <= 1'b0;
      end else if (i_div != div_q) begin
         cnt    <= i_div;  // clean restart at the new rate
         div_q  <= i_div;
         o_rate <= 1'b0;
      end else if (cnt == '0) begin
         cnt    <= div_q;  // wrap
         o_rate <= 1'b1;
      end else begin
         cnt    <= cnt - 1'b1;
         o_rate <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/uart_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_apb_regs import uart_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst,
   // apb3 slave
   input  logic        i_psel,
   input  logic        i_penable,
   input  logic        i_pwrite,
   input  apb_addr_t   i_paddr,
   input  logic [31:0] i_pwdata,
   output logic [31:0] o_prdata,
   output logic        o_pready,
   output logic        o_pslverr,
   // transmit side
   output baud_div_t   o_div,
   output logic        o_tx_start,
   output uart_data_t  o_tx_data,
   input  logic        i_tx_busy,
   input  logic        i_tx_done,
   // receive side
   input  logic        i_rx_valid,
   input  uart_data_t  i_rx_data,
   input  logic        i_frame_err,
   output logic        o_irq
);

   logic       access;     // apb access phase
   logic       addr_hit;   // one of the four mapped offsets
   logic       wr_en;
   logic       rd_rxdata;  // read with side effects
   logic       tx_busy;    // busy as seen by software
   logic       rx_valid;
   logic       frame_err;
   logic       overrun;
   uart_data_t rx_data_q;

   assign access    = i_psel && i_penable;
   assign addr_hit  = (i_paddr == REG_TXDATA) || (i_paddr == REG_RXDATA) ||
                      (i_paddr == REG_STATUS) || (i_paddr == REG_DIV);
   assign wr_en     = access && i_pwrite && addr_hit;
   assign rd_rxdata = access && !i_pwrite && (i_paddr == REG_RXDATA);

   assign o_pready  = 1'b1;  // no wait states
   assign o_pslverr = access && !addr_hit;
   assign o_irq     = rx_valid;
   assign tx_busy   = i_tx_busy || o_tx_start;  // covers the start cycle

   // divisor and transmit request
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_div      <= '0;
         o_tx_start <= 1'b0;
      end else begin
         o_tx_start <= 1'b0;
         if (wr_en && (i_paddr == REG_DIV)) begin
            o_div <= i_pwdata[DIV_W-1:0];
         end
         // dropped while a frame is in flight
         if (wr_en && (i_paddr == REG_TXDATA) && !tx_busy && !i_tx_done) begin
            o_tx_start <= 1'b1;
         end
      end
   end

   // transmit byte is loaded with the request
   always_ff @(posedge i_clk) begin
      if (wr_en && (i_paddr == REG_TXDATA) && !tx_busy && !i_tx_done) begin
         o_tx_data <= i_pwdata[DATA_W-1:0];
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rx_valid) begin
         rx_data_q <= i_rx_data;  // newest character always wins
      end
   end

   // sticky flags, a new event beats a clear in the same cycle
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rx_valid  <= 1'b0;
         frame_err <= 1'b0;
         overrun   <= 1'b0;
      end else begin
         if (rd_rxdata) begin
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
         end
         if (wr_en && (i_paddr == REG_STATUS) && i_pwdata[2]) begin
            frame_err <= 1'b0;  // write one to clear
         end
         if (i_rx_valid) begin
            rx_valid <= 1'b1;
            if (rx_valid && !rd_rxdata) begin
               overrun <= 1'b1;
            end
         end
         if (i_frame_err) begin
            frame_err <= 1'b1;
         end
      end
   end

   // read mux, only drives data in the access phase
   always_comb begin
      o_prdata = '0;
      if (access && !i_pwrite) begin
         case (i_paddr)
            REG_TXDATA: o_prdata = {{(32 - DATA_W){1'b0}}, o_tx_data};
            REG_RXDATA: o_prdata = {{(32 - DATA_W){1'b0}}, rx_data_q};
            REG_STATUS: o_prdata = {28'b0, overrun, frame_err, rx_valid, tx_busy};
            REG_DIV:    o_prdata = {{(32 - DIV_W){1'b0}}, o_div};
            default:    o_prdata = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

   // widths
   localparam int DATA_W     = 8;   // character width, fixed by the register map
   localparam int OVERSAMPLE = 16;  // rate ticks per bit
   localparam int DIV_W      = 16;  // baud divisor width
   localparam int ADDR_W     = 4;   // apb address width

   // vector types
   typedef logic [DATA_W-1:0] uart_data_t;
   typedef logic [DIV_W-1:0]  baud_div_t;
   typedef logic [ADDR_W-1:0] apb_addr_t;
   typedef logic [3:0]        tick_cnt_t;  // counts 0..OVERSAMPLE-1

   // register map, byte offsets
   localparam apb_addr_t REG_TXDATA = 4'h0;
   localparam apb_addr_t REG_RXDATA = 4'h4;
   localparam apb_addr_t REG_STATUS = 4'h8;
   localparam apb_addr_t REG_DIV    = 4'hC;

   // transmitter fsm
   typedef enum logic {
      TX_IDLE,
      TX_SEND
   } tx_state_t;

   // receiver fsm
   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

endpackage

`default_nettype wire

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
   input  logic       i_clk,
   input  logic       i_rst,
   input  logic       i_rate,
   input  logic       i_rx,
   output uart_data_t o_rx_data,
   output logic       o_rx_valid,
   output logic       o_frame_err
);

   rx_state_t  state;
   tick_cnt_t  tick_cnt;  // ticks since the last sample point
   logic [2:0] bit_idx;   // data bit being sampled
   logic       rx_meta;   // first synchronizer stage
   logic       rx_s;      // synchronized line
   uart_data_t data_sr;   // bits arrive lsb first

   assign o_rx_data = data_sr;

   // two flop synchronizer, idle level is high
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rx_meta <= 1'b1;
         rx_s    <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_s    <= rx_meta;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state       <= RX_IDLE;
         tick_cnt    <= '0;
         bit_idx     <= '0;
         o_rx_valid  <= 1'b0;
         o_frame_err <= 1'b0;
      end else begin
         o_rx_valid  <= 1'b0;
         o_frame_err <= 1'b0;
         case (state)
            RX_IDLE: begin
               if (!rx_s) begin  // possible start edge
                  tick_cnt <= '0;
                  state    <= RX_START;
               end
            end

            RX_START: begin
               if (i_rate) begin
                  if (tick_cnt == tick_cnt_t'(OVERSAMPLE / 2 - 1)) begin
                     // middle of the start bit
                     tick_cnt <= '0;
                     bit_idx  <= '0;
                     state    <= rx_s ? RX_IDLE : RX_DATA;  // high here is a glitch
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end

            RX_DATA: begin
               if (i_rate) begin
                  if (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1)) begin
                     tick_cnt <= '0;
                     data_sr  <= {rx_s, data_sr[DATA_W-1:1]};
                     if (bit_idx == 3'(DATA_W - 1)) begin
                        state <= RX_STOP;
                     end else begin
                        bit_idx <= bit_idx + 1'b1;
                     end
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end

            RX_STOP: begin
               if (i_rate) begin
                  if (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1)) begin
                     // mid stop bit, must be high
                     o_rx_valid  <= rx_s;
                     o_frame_err <= !rx_s;
                     tick_cnt    <= '0;
                     state       <= RX_IDLE;
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end

            default: state <= RX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_top import uart_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic        i_psel,
   input  logic        i_penable,
   input  logic        i_pwrite,
   input  apb_addr_t   i_paddr,
   input  logic [31:0] i_pwdata,
   output logic [31:0] o_prdata,
   output logic        o_pready,
   output logic        o_pslverr,
   input  logic        i_rx,
   output logic        o_tx,
   output logic        o_irq
);

   baud_div_t  div;
   logic       rate;       // 16x tick shared by tx and rx
   logic       tx_start;
   uart_data_t tx_data;
   logic       tx_busy;
   logic       tx_done;
   logic       rx_valid;
   uart_data_t rx_data;
   logic       frame_err;

   uart_apb_regs u_regs (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_psel      (i_psel),
      .i_penable   (i_penable),
      .i_pwrite    (i_pwrite),
      .i_paddr     (i_paddr),
      .i_pwdata    (i_pwdata),
      .o_prdata    (o_prdata),
      .o_pready    (o_pready),
      .o_pslverr   (o_pslverr),
      .o_div       (div),
      .o_tx_start  (tx_start),
      .o_tx_data   (tx_data),
      .i_tx_busy   (tx_busy),
      .i_tx_done   (tx_done),
      .i_rx_valid  (rx_valid),
      .i_rx_data   (rx_data),
      .i_frame_err (frame_err),
      .o_irq       (o_irq)
   );

   baud_tick_gen u_baud (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_div  (div),
      .o_rate (rate)
   );

   uart_tx u_tx (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_rate       (rate),
      .i_data_ready (tx_start),
      .i_data       (tx_data),
      .o_tx         (o_tx),
      .o_tx_done    (tx_done),
      .o_busy       (tx_busy)
   );

   uart_rx u_rx (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_rate      (rate),
      .i_rx        (i_rx),
      .o_rx_data   (rx_data),
      .o_rx_valid  (rx_valid),
      .o_frame_err (frame_err)
   );

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
   input  logic       i_clk,
   input  logic       i_rst,
   input  logic       i_rate,
   input  logic       i_data_ready,
   input  uart_data_t i_data,
   output logic       o_tx,
   output logic       o_tx_done,
   output logic       o_busy
);

   tx_state_t         state;
   tick_cnt_t         tick_cnt;   // position inside the current bit
   logic [3:0]        bit_cnt;    // frame bits already put on the line
   logic [DATA_W+1:0] shift_reg;  // stop, data, start; lsb goes out first

   assign o_busy = (state == TX_SEND);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state     <= TX_IDLE;
         tick_cnt  <= '0;
         bit_cnt   <= '0;
         shift_reg <= '1;
         o_tx      <= 1'b1;  // line idles high
         o_tx_done <= 1'b0;
      end else begin
         o_tx_done <= 1'b0;  // single cycle pulse
         case (state)
            TX_IDLE: begin
               o_tx <= 1'b1;
               if (i_data_ready) begin
                  shift_reg <= {1'b1, i_data, 1'b0};
                  tick_cnt  <= '0;
                  bit_cnt   <= '0;
                  state     <= TX_SEND;
               end
            end

            TX_SEND: begin
               if (i_rate) begin
                  if (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1)) begin
                     tick_cnt <= '0;
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end

                  // bit boundary every OVERSAMPLE ticks
                  if (tick_cnt == '0) begin
                     if (bit_cnt == 4'(DATA_W + 2)) begin
                        // stop bit has run its full length
                        o_tx_done <= 1'b1;
                        o_tx      <= 1'b1;
                        state     <= TX_IDLE;
                     end else begin
                        o_tx      <= shift_reg[0];
                        shift_reg <= {1'b1, shift_reg[DATA_W+1:1]};
                        bit_cnt   <= bit_cnt + 1'b1;
                     end
                  end
               end
            end

            default: state <= TX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire
